//--- design/mult_pkg.sv
package mult_pkg;

    localparam int OP_W       = 16;
    localparam int PROD_W     = 32;
    localparam int PP_ROWS    = 16;
    localparam int CLA_GROUPS = PROD_W / 4;    // 4-bit lookahead groups

    // word addresses
    localparam logic [1:0] ADR_OPERAND = 2'd0;
    localparam logic [1:0] ADR_RESULT  = 2'd1;
    localparam logic [1:0] ADR_STATUS  = 2'd2;

    // status word bits
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;

    typedef struct packed {
        logic [OP_W-1:0] b;    // high half of bus word
        logic [OP_W-1:0] a;
    } mult_op_t;

    typedef logic [7:0][PROD_W-1:0] rows8_t;

    typedef struct packed {
        logic [PROD_W-1:0] carry;
        logic [PROD_W-1:0] sum;
    } csa_pair_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [1:0]        adr;
        logic [PROD_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic [PROD_W-1:0] dat_r;
        logic              ack;
    } wb_rsp_t;

endpackage

//--- design/compressor_row.sv
module compressor_row
    import mult_pkg::*;
(
    input  logic [PROD_W-1:0] x1,
    input  logic [PROD_W-1:0] x2,
    input  logic [PROD_W-1:0] x3,
    input  logic [PROD_W-1:0] x4,
    output csa_pair_t         pair
);

    logic [PROD_W-1:0] cin;      // cout of the bit below
    logic [PROD_W-1:0] sum;
    logic [PROD_W-1:0] carry;    // already at its weight

    assign cin[0]   = 1'b0;
    assign carry[0] = 1'b0;

    for (genvar i = 0; i < PROD_W; i++) begin : g_cell
        logic s_inter;

        assign s_inter = x1[i] ^ x2[i] ^ x3[i];
        assign sum[i]  = s_inter ^ x4[i] ^ cin[i];

        // carries out of bit 31 fall off the 32-bit product
        if (i < PROD_W - 1) begin : g_carry
            // cout does not depend on cin, so no ripple along the row
            assign cin[i+1] = (x1[i] & x2[i]) | (x2[i] & x3[i]) | (x3[i] & x1[i]);
            assign carry[i+1] = (s_inter & x4[i]) | (x4[i] & cin[i])
                              | (cin[i] & s_inter);
        end
    end

    assign pair.sum   = sum;
    assign pair.carry = carry;

endmodule

//--- design/pipe_stage.sv
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;    // hold between products
        end
    end

endmodule

//--- design/cla_adder.sv
module cla_adder
    import mult_pkg::*;
(
    input  csa_pair_t         rows,
    output logic [PROD_W-1:0] sum
);

    logic [PROD_W-1:0]       g;
    logic [PROD_W-1:0]       p;
    logic [CLA_GROUPS-2:0]   grp_g;    // top group needs no carry out
    logic [CLA_GROUPS-2:0]   grp_p;
    logic [CLA_GROUPS-1:0]   gc;       // carry into each group

    // carries into bits 0..3 of a group
    function automatic logic [3:0] bit_carries(input logic [3:0] gi, input logic [3:0] pi,
                                               input logic ci);
        logic [3:0] c;
        c[0] = ci;
        c[1] = gi[0] | (pi[0] & ci);
        c[2] = gi[1] | (pi[1] & gi[0]) | (pi[1] & pi[0] & ci);
        c[3] = gi[2] | (pi[2] & gi[1]) | (pi[2] & pi[1] & gi[0])
             | (pi[2] & pi[1] & pi[0] & ci);
        return c;
    endfunction

    function automatic logic grp_gen(input logic [3:0] gi, input logic [3:0] pi);
        return gi[3] | (pi[3] & gi[2]) | (pi[3] & pi[2] & gi[1])
             | (pi[3] & pi[2] & pi[1] & gi[0]);
    endfunction

    assign g = rows.sum & rows.carry;
    assign p = rows.sum ^ rows.carry;

    for (genvar k = 0; k < CLA_GROUPS; k++) begin : g_grp
        logic [3:0] c;

        if (k < CLA_GROUPS - 1) begin : g_gp
            assign grp_g[k] = grp_gen(g[4*k +: 4], p[4*k +: 4]);
            assign grp_p[k] = &p[4*k +: 4];
        end
        assign c            = bit_carries(g[4*k +: 4], p[4*k +: 4], gc[k]);
        assign sum[4*k +: 4] = p[4*k +: 4] ^ c;
    end

    // second level, flat across the groups with carry-in zero
    always_comb begin : group_lookahead
        logic term;
        gc = '0;
        for (int k = 1; k < CLA_GROUPS; k++) begin
            for (int j = 0; j < k; j++) begin
                term = grp_g[j];
                for (int m = j + 1; m < k; m++) begin
                    term = term & grp_p[m];
                end
                gc[k] = gc[k] | term;
            end
        end
    end

endmodule

//--- design/dadda_tree.sv
module dadda_tree
    import mult_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mult_op_t  op,
    input  logic      start,
    output csa_pair_t rows,
    output logic      valid
);

    logic [PP_ROWS-1:0][PROD_W-1:0] pp;
    rows8_t                         l1_rows;
    rows8_t                         s1_rows;
    logic                           s1_valid;
    csa_pair_t                      l2_pair [2];
    csa_pair_t                      l3_pair;

    // row j is a gated by b[j], placed at weight j
    for (genvar j = 0; j < PP_ROWS; j++) begin : g_pp
        assign pp[j] = {{(PROD_W-OP_W){1'b0}}, op.a & {OP_W{op.b[j]}}} << j;
    end

    // 16 -> 8
    for (genvar k = 0; k < PP_ROWS / 4; k++) begin : g_lvl1
        csa_pair_t pair;

        compressor_row u_row (
            .x1   (pp[4*k]),
            .x2   (pp[4*k+1]),
            .x3   (pp[4*k+2]),
            .x4   (pp[4*k+3]),
            .pair (pair)
        );
        assign l1_rows[2*k]   = pair.sum;
        assign l1_rows[2*k+1] = pair.carry;
    end

    pipe_stage #(.payload_t(rows8_t)) u_stage1 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (start),
        .in_data   (l1_rows),
        .out_valid (s1_valid),
        .out_data  (s1_rows)
    );

    // 8 -> 4
    for (genvar k = 0; k < 2; k++) begin : g_lvl2
        compressor_row u_row (
            .x1   (s1_rows[4*k]),
            .x2   (s1_rows[4*k+1]),
            .x3   (s1_rows[4*k+2]),
            .x4   (s1_rows[4*k+3]),
            .pair (l2_pair[k])
        );
    end

    // 4 -> 2
    compressor_row u_lvl3 (
        .x1   (l2_pair[0].sum),
        .x2   (l2_pair[0].carry),
        .x3   (l2_pair[1].sum),
        .x4   (l2_pair[1].carry),
        .pair (l3_pair)
    );

    pipe_stage #(.payload_t(csa_pair_t)) u_stage2 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s1_valid),
        .in_data   (l3_pair),
        .out_valid (valid),
        .out_data  (rows)
    );

endmodule

//--- design/wb_mult_ctrl.sv
module wb_mult_ctrl
    import mult_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  wb_req_t           wb_req,
    output wb_rsp_t           wb_rsp,
    output mult_op_t          op,
    output logic              start,
    input  logic              prod_valid,
    input  logic [PROD_W-1:0] product
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t            state;
    logic              req;
    logic              op_wr;
    logic              accept;
    logic              ack_q;
    logic [PROD_W-1:0] dat_r_q;
    logic [PROD_W-1:0] rd_data;
    logic [PROD_W-1:0] status;
    logic [PROD_W-1:0] result;
    logic              done;

    assign req   = wb_req.cyc & wb_req.stb;
    assign op_wr = req & wb_req.we & (wb_req.adr == ADR_OPERAND);

    // no new transfer while ack is out; operand writes wait for idle
    assign accept = req & ~ack_q & ~(op_wr & (state == BUSY));

    always_comb begin
        status            = '0;
        status[STAT_BUSY] = (state == BUSY);
        status[STAT_DONE] = done;
    end

    always_comb begin
        case (wb_req.adr)
            ADR_OPERAND: rd_data = op;
            ADR_RESULT:  rd_data = result;
            ADR_STATUS:  rd_data = status;
            default:     rd_data = '0;    // unused address
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            ack_q  <= 1'b0;
            start  <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            ack_q <= accept;
            start <= accept & op_wr;
            if (accept && op_wr) begin
                state <= BUSY;
                done  <= 1'b0;
            end else if (prod_valid) begin
                state  <= IDLE;
                done   <= 1'b1;
                result <= product;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dat_r_q <= rd_data;
        end
        if (accept && op_wr) begin
            op <= mult_op_t'(wb_req.dat_w);
        end
    end

    assign wb_rsp = '{dat_r: dat_r_q, ack: ack_q};

endmodule

//--- design/wb_multiplier.sv
module wb_multiplier
    import mult_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    mult_op_t          op;
    logic              start;
    csa_pair_t         rows;
    logic              rows_valid;
    logic [PROD_W-1:0] product;

    wb_mult_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .op         (op),
        .start      (start),
        .prod_valid (rows_valid),
        .product    (product)
    );

    // two register stages between start and rows_valid
    dadda_tree u_tree (
        .clk   (clk),
        .rst   (rst),
        .op    (op),
        .start (start),
        .rows  (rows),
        .valid (rows_valid)
    );

    cla_adder u_adder (
        .rows (rows),
        .sum  (product)    // sampled by ctrl with rows_valid
    );

endmodule

//--- dv/tb_wb_multiplier.sv
module tb_wb_multiplier
    import mult_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    mult_op_t          last_op;     // last operand word written
    logic [PROD_W-1:0] last_prod;   // its expected product

    wb_multiplier u_dut (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [PROD_W-1:0] got,
                               input logic [PROD_W-1:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("FAILED at time %0t: %s expected 0x%08h, got 0x%08h",
                               $time, name, exp, got));
        end
    endtask

    function automatic logic [PROD_W-1:0] status_word(input logic busy, input logic done);
        logic [PROD_W-1:0] w;
        w            = '0;
        w[STAT_BUSY] = busy;
        w[STAT_DONE] = done;
        return w;
    endfunction

    // entered and left on a falling edge
    task automatic bus_cycle(input logic we, input logic [1:0] adr,
                             input logic [PROD_W-1:0] dat_w,
                             output logic [PROD_W-1:0] dat_r, output int waits);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat_w};
        waits  = 0;
        do begin
            @(negedge clk);
            waits++;
            if (waits > 20) begin
                stop_run($sformatf("no ack within 20 cycles for an access to address %0d",
                                   adr));
            end
        end while (!wb_rsp.ack);
        dat_r = wb_rsp.dat_r;
        @(negedge clk);    // transfer completed at the edge in between
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [PROD_W-1:0] data,
                            output int waits);
        logic [PROD_W-1:0] unused;
        bus_cycle(1'b1, adr, data, unused, waits);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [PROD_W-1:0] data);
        int waits;
        bus_cycle(1'b0, adr, '0, data, waits);
        check_value("read wait cycles", waits, 1);    // reads are never held off
    endtask

    task automatic wait_done();
        logic [PROD_W-1:0] stat;
        int                polls;
        polls = 0;
        do begin
            polls++;
            if (polls > 16) begin
                stop_run("done bit did not set within 16 status reads");
            end
            wb_read(ADR_STATUS, stat);
        end while (!stat[STAT_DONE]);
        check_value("status when done", stat, status_word(1'b0, 1'b1));
    endtask

    task automatic multiply(input logic [OP_W-1:0] a, input logic [OP_W-1:0] b);
        logic [PROD_W-1:0] stat;
        logic [PROD_W-1:0] res;
        int                waits;
        last_op   = '{b: b, a: a};
        last_prod = PROD_W'(a) * PROD_W'(b);
        wb_write(ADR_OPERAND, last_op, waits);
        wb_read(ADR_STATUS, stat);    // lands before the three cycle latency ends
        check_value("status after operand write", stat, status_word(1'b1, 1'b0));
        wait_done();
        wb_read(ADR_RESULT, res);
        check_value("result", res, last_prod);
    endtask

    initial begin
        logic [PROD_W-1:0] rd;
        logic [OP_W-1:0]   a;
        logic [OP_W-1:0]   b;
        int                waits;

        void'($urandom(32'hf56a_1e88));
        rst       = 1'b1;
        wb_req    = '0;
        last_op   = '0;
        last_prod = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset state
        repeat (3) begin
            @(negedge clk);
            check_value("ack while idle", PROD_W'(wb_rsp.ack), '0);
        end
        wb_read(ADR_STATUS, rd);
        check_value("status after reset", rd, '0);
        wb_read(ADR_RESULT, rd);
        check_value("result after reset", rd, '0);

        // corner operands
        multiply(16'h0000, 16'h1234);
        multiply(16'hbeef, 16'h0000);
        multiply(16'h0001, 16'h5a5a);
        multiply(16'hc3d2, 16'h0001);
        multiply(16'hffff, 16'hffff);
        multiply(16'h8000, 16'h8000);
        multiply(16'hffff, 16'h0001);

        for (int i = 0; i < 200; i++) begin
            a = OP_W'($urandom());
            b = OP_W'($urandom());
            multiply(a, b);
        end

        // second operand write is held off while busy
        wb_write(ADR_OPERAND, {16'h00ff, 16'h1357}, waits);
        check_value("first operand write wait cycles", waits, 1);
        last_op   = '{b: 16'h7531, a: 16'hfedc};
        last_prod = PROD_W'(16'hfedc) * PROD_W'(16'h7531);
        wb_write(ADR_OPERAND, last_op, waits);
        check_value("stalled operand write wait cycles", waits, 3);
        wb_read(ADR_STATUS, rd);
        check_value("status after stalled write", rd, status_word(1'b1, 1'b0));
        wait_done();
        wb_read(ADR_RESULT, rd);
        check_value("result after stall", rd, last_prod);

        // writes outside OPERAND are acked and dropped
        wb_write(ADR_RESULT, 32'hdead_beef, waits);
        check_value("result write wait cycles", waits, 1);
        wb_write(ADR_STATUS, 32'hffff_ffff, waits);
        check_value("status write wait cycles", waits, 1);
        wb_read(ADR_RESULT, rd);
        check_value("result after ignored write", rd, last_prod);
        wb_read(ADR_STATUS, rd);
        check_value("status after ignored write", rd, status_word(1'b0, 1'b1));
        wb_read(2'd3, rd);
        check_value("unused address", rd, '0);
        wb_read(ADR_OPERAND, rd);
        check_value("operand readback", rd, last_op);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
design/mult_pkg.sv
design/compressor_row.sv
design/pipe_stage.sv
design/cla_adder.sv
design/dadda_tree.sv
design/wb_mult_ctrl.sv
design/wb_multiplier.sv
dv/tb_wb_multiplier.sv

//--- run.sh
#!/bin/sh
# build and run the Wishbone multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_wb_multiplier -f verilog.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
